// ==== source/memdep_pkg.sv ====
package memdep_pkg;

    // pipeline widths
    localparam int RENAME_WIDTH      = 4;
    localparam int STORE_ISSUE_WIDTH = 2;

    // table geometry
    localparam int FOLDPC_WIDTH  = 10;
    localparam int SSID_WIDTH    = 5;
    localparam int ROB_IDX_WIDTH = 7;
    localparam int SSIT_ENTRIES  = 1 << FOLDPC_WIDTH;
    localparam int LFST_ENTRIES  = 1 << SSID_WIDTH;

    // periodic flush of all training state
    localparam int CLEAR_PERIOD    = 25000;
    localparam int CLEAR_CNT_WIDTH = $clog2(CLEAR_PERIOD);

    typedef logic [FOLDPC_WIDTH-1:0]  foldpc_t;
    typedef logic [SSID_WIDTH-1:0]    ssid_t;
    typedef logic [ROB_IDX_WIDTH-1:0] rob_idx_t;

    typedef struct packed {
        logic    valid;
        foldpc_t foldpc;
    } rename_slot_t;

    typedef struct packed {
        logic     is_store;
        rob_idx_t rob_idx;
    } dispatch_slot_t;

    typedef struct packed {
        logic  found;
        ssid_t ssid;
    } ssit_hit_t;

    typedef struct packed {
        logic     valid;
        foldpc_t  foldpc;
        rob_idx_t rob_idx;
    } store_issue_t;

    typedef struct packed {
        logic    valid;
        foldpc_t store_foldpc;
        foldpc_t load_foldpc;
    } violation_t;

    typedef struct packed {
        logic     should_wait;
        rob_idx_t rob_idx;
    } mem_dep_t;

    // encoded as {store found, load found}
    typedef enum logic [1:0] {
        VIO_NEW_SET    = 2'b00,
        VIO_JOIN_LOAD  = 2'b01,
        VIO_JOIN_STORE = 2'b10,
        VIO_MERGE      = 2'b11
    } vio_mode_e;

endpackage

// ==== source/ssit.sv ====
`timescale 1ns/1ps

module ssit (
    input  logic                                                        clk,
    input  logic                                                        rst,
    input  logic                                                        i_stall,
    input  memdep_pkg::rename_slot_t [memdep_pkg::RENAME_WIDTH-1:0]      i_rename,
    input  memdep_pkg::store_issue_t [memdep_pkg::STORE_ISSUE_WIDTH-1:0] i_store_issue,
    input  memdep_pkg::violation_t                                      i_violation,
    output memdep_pkg::ssit_hit_t [memdep_pkg::RENAME_WIDTH-1:0]         o_s1_hit,
    output memdep_pkg::ssit_hit_t [memdep_pkg::STORE_ISSUE_WIDTH-1:0]    o_issue_hit,
    output memdep_pkg::rob_idx_t [memdep_pkg::STORE_ISSUE_WIDTH-1:0]     o_issue_rob,
    output logic                                                        o_set_clear
);
    import memdep_pkg::*;

    logic [CLEAR_CNT_WIDTH-1:0] clear_cnt;
    logic                       set_clear;

    logic [SSIT_ENTRIES-1:0] ssit_vld;
    ssid_t                   ssit_mem [SSIT_ENTRIES];

    // violation stage 1 state
    logic      vio_s1_valid;
    logic      vio_store_found;
    logic      vio_load_found;
    ssid_t     vio_store_ssid;
    ssid_t     vio_load_ssid;
    foldpc_t   vio_store_pc;
    foldpc_t   vio_load_pc;
    vio_mode_e vio_mode;
    ssid_t     new_ssid;

    // free running clear counter, wraps on its last cycle
    assign set_clear   = (clear_cnt == CLEAR_CNT_WIDTH'(CLEAR_PERIOD - 1));
    assign o_set_clear = set_clear;

    always_ff @(posedge clk) begin
        if (rst || set_clear) begin
            clear_cnt <= '0;
        end else begin
            clear_cnt <= clear_cnt + 1'b1;
        end
    end

    // rename lookup, holds while stalled
    always_ff @(posedge clk) begin
        if (rst || set_clear) begin
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                o_s1_hit[i].found <= 1'b0;
            end
        end else if (!i_stall) begin
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                o_s1_hit[i].found <= i_rename[i].valid && ssit_vld[i_rename[i].foldpc];
                o_s1_hit[i].ssid  <= ssit_mem[i_rename[i].foldpc];
            end
        end
    end

    // issued store lookup, independent of stall
    always_ff @(posedge clk) begin
        if (rst || set_clear) begin
            for (int k = 0; k < STORE_ISSUE_WIDTH; k++) begin
                o_issue_hit[k].found <= 1'b0;
            end
        end else begin
            for (int k = 0; k < STORE_ISSUE_WIDTH; k++) begin
                o_issue_hit[k].found <= i_store_issue[k].valid &&
                                        ssit_vld[i_store_issue[k].foldpc];
                o_issue_hit[k].ssid  <= ssit_mem[i_store_issue[k].foldpc];
                o_issue_rob[k]       <= i_store_issue[k].rob_idx;
            end
        end
    end

    // violation stage 1: look up both pcs
    always_ff @(posedge clk) begin
        if (rst) begin
            vio_s1_valid <= 1'b0;
        end else begin
            vio_s1_valid <= i_violation.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_violation.valid) begin
            vio_store_found <= ssit_vld[i_violation.store_foldpc];
            vio_load_found  <= ssit_vld[i_violation.load_foldpc];
            vio_store_ssid  <= ssit_mem[i_violation.store_foldpc];
            vio_load_ssid   <= ssit_mem[i_violation.load_foldpc];
            vio_store_pc    <= i_violation.store_foldpc;
            vio_load_pc     <= i_violation.load_foldpc;
        end
    end

    // violation stage 2: classify and train
    assign vio_mode = vio_mode_e'({vio_store_found, vio_load_found});
    // fresh set named after the store
    assign new_ssid = vio_store_pc[SSID_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (rst || set_clear) begin
            ssit_vld <= '0;
        end else if (vio_s1_valid) begin
            case (vio_mode)
                VIO_NEW_SET: begin
                    ssit_vld[vio_store_pc] <= 1'b1;
                    ssit_vld[vio_load_pc]  <= 1'b1;
                end
                VIO_JOIN_LOAD:  ssit_vld[vio_store_pc] <= 1'b1;
                VIO_JOIN_STORE: ssit_vld[vio_load_pc]  <= 1'b1;
                // both already valid
                VIO_MERGE: ;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (vio_s1_valid) begin
            case (vio_mode)
                VIO_NEW_SET: begin
                    ssit_mem[vio_store_pc] <= new_ssid;
                    ssit_mem[vio_load_pc]  <= new_ssid;
                end
                VIO_JOIN_LOAD:  ssit_mem[vio_store_pc] <= vio_load_ssid;
                VIO_JOIN_STORE: ssit_mem[vio_load_pc]  <= vio_store_ssid;
                VIO_MERGE: begin
                    // smaller id survives
                    if (vio_store_ssid > vio_load_ssid) begin
                        ssit_mem[vio_store_pc] <= vio_load_ssid;
                    end else begin
                        ssit_mem[vio_load_pc] <= vio_store_ssid;
                    end
                end
                default: ;
            endcase
        end
    end

    // training pipe holds one violation at a time
    a_vio_spacing: assert property (
        @(posedge clk) disable iff (rst)
        i_violation.valid |=> !i_violation.valid
    ) else $error("violation reported on back to back cycles");

endmodule

// ==== source/lfst.sv ====
`timescale 1ns/1ps

module lfst (
    input  logic                                                          clk,
    input  logic                                                          rst,
    input  logic                                                          i_stall,
    input  memdep_pkg::ssit_hit_t [memdep_pkg::RENAME_WIDTH-1:0]           i_s1_hit,
    input  memdep_pkg::dispatch_slot_t [memdep_pkg::RENAME_WIDTH-1:0]      i_dispatch,
    input  memdep_pkg::ssit_hit_t [memdep_pkg::STORE_ISSUE_WIDTH-1:0]      i_issue_hit,
    input  memdep_pkg::rob_idx_t [memdep_pkg::STORE_ISSUE_WIDTH-1:0]       i_issue_rob,
    input  logic                                                          i_set_clear,
    output memdep_pkg::mem_dep_t [memdep_pkg::RENAME_WIDTH-1:0]            o_rd
);
    import memdep_pkg::*;

    logic [LFST_ENTRIES-1:0] lfst_vld;
    rob_idx_t                lfst_rob [LFST_ENTRIES];

    logic [RENAME_WIDTH-1:0] insert;

    // found stores in the current dispatch group
    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            insert[i] = i_s1_hit[i].found && i_dispatch[i].is_store;
        end
    end

    // issue clears first so a same-cycle insert overrides it
    always_ff @(posedge clk) begin
        if (rst || i_set_clear) begin
            lfst_vld <= '0;
        end else begin
            for (int k = 0; k < STORE_ISSUE_WIDTH; k++) begin
                // only if the set still names this store
                if (i_issue_hit[k].found &&
                    lfst_rob[i_issue_hit[k].ssid] == i_issue_rob[k]) begin
                    lfst_vld[i_issue_hit[k].ssid] <= 1'b0;
                end
            end
            if (!i_stall) begin
                for (int i = 0; i < RENAME_WIDTH; i++) begin
                    if (insert[i]) begin
                        lfst_vld[i_s1_hit[i].ssid] <= 1'b1;
                    end
                end
            end
        end
    end

    // youngest slot of the group lands last
    always_ff @(posedge clk) begin
        if (!i_stall) begin
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                if (insert[i]) begin
                    lfst_rob[i_s1_hit[i].ssid] <= i_dispatch[i].rob_idx;
                end
            end
        end
    end

    // raw entry per slot, found is applied downstream
    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            o_rd[i].should_wait = lfst_vld[i_s1_hit[i].ssid];
            o_rd[i].rob_idx     = lfst_rob[i_s1_hit[i].ssid];
        end
    end

    // a stalled group must leave no new valid entry behind
    a_no_insert_on_stall: assert property (
        @(posedge clk) disable iff (rst)
        i_stall |=> ((lfst_vld & ~$past(lfst_vld)) == '0)
    ) else $error("lfst entry inserted during stall");

endmodule

// ==== source/dep_resolve.sv ====
`timescale 1ns/1ps

module dep_resolve (
    input  memdep_pkg::ssit_hit_t [memdep_pkg::RENAME_WIDTH-1:0]      i_s1_hit,
    input  memdep_pkg::dispatch_slot_t [memdep_pkg::RENAME_WIDTH-1:0] i_dispatch,
    input  memdep_pkg::mem_dep_t [memdep_pkg::RENAME_WIDTH-1:0]       i_lfst_rd,
    output memdep_pkg::mem_dep_t [memdep_pkg::RENAME_WIDTH-1:0]       o_dep
);
    import memdep_pkg::*;

    mem_dep_t [RENAME_WIDTH-1:0] dep;

    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            dep[i] = '0;

            // older in-flight store of this set
            if (i_s1_hit[i].found && i_lfst_rd[i].should_wait) begin
                dep[i].should_wait = 1'b1;
                dep[i].rob_idx     = i_lfst_rd[i].rob_idx;
            end

            // in-group bypass, ascending so the nearest older slot wins
            for (int j = 0; j < i; j++) begin
                if (i_s1_hit[i].found && i_s1_hit[j].found &&
                    i_dispatch[j].is_store &&
                    i_s1_hit[i].ssid == i_s1_hit[j].ssid) begin
                    dep[i].should_wait = 1'b1;
                    dep[i].rob_idx     = i_dispatch[j].rob_idx;
                end
            end
        end
    end

    assign o_dep = dep;

    // an untrained slot never waits, whatever the lfst holds
    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            a_wait_needs_found: assert final (!o_dep[i].should_wait || i_s1_hit[i].found)
                else $error("slot %0d waits without a store set", i);
        end
    end

endmodule

// ==== source/storeset.sv ====
`timescale 1ns/1ps

module storeset (
    input  logic                                                        clk,
    input  logic                                                        rst,
    input  logic                                                        i_stall,
    input  memdep_pkg::rename_slot_t [memdep_pkg::RENAME_WIDTH-1:0]      i_rename,
    input  memdep_pkg::dispatch_slot_t [memdep_pkg::RENAME_WIDTH-1:0]    i_dispatch,
    input  memdep_pkg::store_issue_t [memdep_pkg::STORE_ISSUE_WIDTH-1:0] i_store_issue,
    input  memdep_pkg::violation_t                                      i_violation,
    output memdep_pkg::mem_dep_t [memdep_pkg::RENAME_WIDTH-1:0]          o_dep
);
    import memdep_pkg::*;

    // rename to dispatch stage
    ssit_hit_t [RENAME_WIDTH-1:0] s1_hit;
    mem_dep_t  [RENAME_WIDTH-1:0] lfst_rd;

    // issued store lookup results
    ssit_hit_t [STORE_ISSUE_WIDTH-1:0] issue_hit;
    rob_idx_t  [STORE_ISSUE_WIDTH-1:0] issue_rob;

    logic set_clear;

    ssit u_ssit (
        .clk           (clk),
        .rst           (rst),
        .i_stall       (i_stall),
        .i_rename      (i_rename),
        .i_store_issue (i_store_issue),
        .i_violation   (i_violation),
        .o_s1_hit      (s1_hit),
        .o_issue_hit   (issue_hit),
        .o_issue_rob   (issue_rob),
        .o_set_clear   (set_clear)
    );

    lfst u_lfst (
        .clk         (clk),
        .rst         (rst),
        .i_stall     (i_stall),
        .i_s1_hit    (s1_hit),
        .i_dispatch  (i_dispatch),
        .i_issue_hit (issue_hit),
        .i_issue_rob (issue_rob),
        .i_set_clear (set_clear),
        .o_rd        (lfst_rd)
    );

    // combinational, valid in the dispatch cycle
    dep_resolve u_dep_resolve (
        .i_s1_hit   (s1_hit),
        .i_dispatch (i_dispatch),
        .i_lfst_rd  (lfst_rd),
        .o_dep      (o_dep)
    );

endmodule

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic o_clk,
    output logic o_rst
);
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 5;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // released on the edge ending the last reset cycle
    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

// ==== verif/tb_storeset.sv ====
`timescale 1ns/1ps

module tb_storeset;
    import memdep_pkg::*;

    typedef mem_dep_t  [RENAME_WIDTH-1:0] dep_vec_t;
    typedef ssit_hit_t [RENAME_WIDTH-1:0] hit_vec_t;

    localparam int CLK_PERIOD    = 100;
    localparam int TEST_CYCLES   = 400;
    localparam int MARGIN_CYCLES = 1000;
    // trained pcs stay below the filler range
    localparam foldpc_t FILLER_BASE = 10'h200;
    localparam foldpc_t ST_A = 10'h041;
    localparam foldpc_t LD_A = 10'h102;
    localparam foldpc_t LD_C = 10'h0c3;
    localparam foldpc_t ST_D = 10'h0a7;
    localparam foldpc_t ST_B = 10'h1e8;
    localparam foldpc_t LD_B = 10'h1a4;

    logic clk;
    logic rst;
    logic stall;
    rename_slot_t   [RENAME_WIDTH-1:0]      rename;
    dispatch_slot_t [RENAME_WIDTH-1:0]      dispatch;
    store_issue_t   [STORE_ISSUE_WIDTH-1:0] store_issue;
    violation_t                             violation;
    dep_vec_t                               dep;

    logic     ren_go;
    logic     stall_chk;
    dep_vec_t exp_dep;
    int       cyc;
    integer   seed;
    rename_slot_t   [RENAME_WIDTH-1:0] grp_ren;
    dispatch_slot_t [RENAME_WIDTH-1:0] grp_dsp;

    // trained set of each pc and last store of each set
    logic     m_vld  [SSIT_ENTRIES];
    ssid_t    m_ssid [SSIT_ENTRIES];
    logic     l_vld  [LFST_ENTRIES];
    rob_idx_t l_rob  [LFST_ENTRIES];

    tb_clk_gen u_clk_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    storeset UUT (
        .clk           (clk),
        .rst           (rst),
        .i_stall       (stall),
        .i_rename      (rename),
        .i_dispatch    (dispatch),
        .i_store_issue (store_issue),
        .i_violation   (violation),
        .o_dep         (dep)
    );

    always @(posedge clk) begin
        if (rst) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    task automatic fail_check(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1, "stopping at first mismatch");
    endtask

    a_dep_match: assert property (
        @(posedge clk) disable iff (rst)
        (ren_go && !stall) |=> (dep == exp_dep)
    ) else fail_check($sformatf("o_dep %h, expected %h", $sampled(dep), $sampled(exp_dep)));

    // held group keeps its prediction
    a_stall_hold: assert property (
        @(posedge clk) disable iff (rst)
        (stall_chk && stall) |=> (dep == exp_dep)
    ) else fail_check($sformatf("o_dep %h moved under stall, expected %h",
                                $sampled(dep), $sampled(exp_dep)));

    function automatic dep_vec_t predict(input hit_vec_t hit);
        dep_vec_t res;
        res = '0;
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            if (hit[s].found) begin
                // nearest older store of the same set in this group
                for (int p = s - 1; p >= 0 && !res[s].should_wait; p--) begin
                    if (hit[p].found && grp_dsp[p].is_store && hit[p].ssid == hit[s].ssid) begin
                        res[s].should_wait = 1'b1;
                        res[s].rob_idx     = grp_dsp[p].rob_idx;
                    end
                end
                if (!res[s].should_wait && l_vld[hit[s].ssid]) begin
                    res[s].should_wait = 1'b1;
                    res[s].rob_idx     = l_rob[hit[s].ssid];
                end
            end
        end
        return res;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            rename   <= '0;
            dispatch <= '0;
            ren_go   <= 1'b0;
        end
    endtask

    // filled slots carry untrained random pcs
    task automatic new_group(input logic filled);
        int rnd;
        grp_ren = '0;
        grp_dsp = '0;
        for (int s = 0; s < RENAME_WIDTH && filled; s++) begin
            rnd = $random(seed);
            grp_ren[s].valid    = 1'b1;
            grp_ren[s].foldpc   = FILLER_BASE | foldpc_t'(rnd[8:0]);
            grp_dsp[s].is_store = rnd[9];
            grp_dsp[s].rob_idx  = rob_idx_t'($random(seed));
        end
    endtask

    task automatic put_slot(input int s, input foldpc_t pc, input logic st, input rob_idx_t rob);
        grp_ren[s].valid    = 1'b1;
        grp_ren[s].foldpc   = pc;
        grp_dsp[s].is_store = st;
        grp_dsp[s].rob_idx  = rob;
    endtask

    // rename edge and then dispatch edge
    // with hold set the group stays stalled in dispatch
    task automatic run_group(input logic hold);
        hit_vec_t hit;
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            hit[s].found = grp_ren[s].valid && m_vld[grp_ren[s].foldpc];
            hit[s].ssid  = m_ssid[grp_ren[s].foldpc];
        end
        @(posedge clk);
        rename   <= grp_ren;
        dispatch <= '0;
        ren_go   <= 1'b1;
        @(posedge clk);
        rename    <= '0;
        dispatch  <= grp_dsp;
        ren_go    <= 1'b0;
        stall     <= hold;
        stall_chk <= hold;
        exp_dep   <= predict(hit);
        for (int s = 0; s < RENAME_WIDTH && !hold; s++) begin
            if (hit[s].found && grp_dsp[s].is_store) begin
                l_vld[hit[s].ssid] = 1'b1;
                l_rob[hit[s].ssid] = grp_dsp[s].rob_idx;
            end
        end
    endtask

    task automatic train_pair(input foldpc_t st_pc, input foldpc_t ld_pc);
        @(posedge clk);
        violation <= '{valid: 1'b1, store_foldpc: st_pc, load_foldpc: ld_pc};
        @(posedge clk);
        violation <= '0;
        if (!m_vld[st_pc] && !m_vld[ld_pc]) begin
            m_ssid[st_pc] = st_pc[SSID_WIDTH-1:0];
            m_ssid[ld_pc] = st_pc[SSID_WIDTH-1:0];
        end else if (!m_vld[st_pc]) begin
            m_ssid[st_pc] = m_ssid[ld_pc];
        end else if (!m_vld[ld_pc]) begin
            m_ssid[ld_pc] = m_ssid[st_pc];
        end else if (m_ssid[st_pc] > m_ssid[ld_pc]) begin
            m_ssid[st_pc] = m_ssid[ld_pc];
        end else begin
            m_ssid[ld_pc] = m_ssid[st_pc];
        end
        m_vld[st_pc] = 1'b1;
        m_vld[ld_pc] = 1'b1;
        idle_cycles(2);
    endtask

    task automatic issue_store(input int lane, input foldpc_t pc, input rob_idx_t rob);
        @(posedge clk);
        store_issue[lane] <= '{valid: 1'b1, foldpc: pc, rob_idx: rob};
        @(posedge clk);
        store_issue <= '0;
        if (m_vld[pc] && l_rob[m_ssid[pc]] == rob) begin
            l_vld[m_ssid[pc]] = 1'b0;
        end
        idle_cycles(2);
    endtask

    initial begin
        seed        = 14;
        stall       = 1'b0;
        rename      = '0;
        dispatch    = '0;
        store_issue = '0;
        violation   = '0;
        ren_go      = 1'b0;
        stall_chk   = 1'b0;
        exp_dep     = '0;
        for (int p = 0; p < SSIT_ENTRIES; p++) begin
            m_vld[p]  = 1'b0;
            m_ssid[p] = '0;
        end
        for (int e = 0; e < LFST_ENTRIES; e++) begin
            l_vld[e] = 1'b0;
            l_rob[e] = '0;
        end
        @(posedge clk);
        while (rst) @(posedge clk);

        // untrained traffic
        repeat (8) begin
            new_group(1'b1);
            run_group(1'b0);
        end

        // new set seen through the in-group bypass and then the lfst
        train_pair(ST_A, LD_A);
        new_group(1'b1);
        put_slot(0, ST_A, 1'b1, 7'd10);
        put_slot(2, LD_A, 1'b0, 7'd12);
        run_group(1'b0);
        new_group(1'b0);
        put_slot(1, LD_A, 1'b0, 7'd13);
        // invalid slot is never found
        grp_ren[3].foldpc = LD_A;
        run_group(1'b0);

        // a wrong rob keeps the entry and the matching rob clears it
        issue_store(1, ST_A, 7'd11);
        new_group(1'b0);
        put_slot(0, LD_A, 1'b0, 7'd14);
        run_group(1'b0);
        issue_store(0, ST_A, 7'd10);
        run_group(1'b0);

        // joins on either side
        train_pair(ST_A, LD_C);
        new_group(1'b1);
        put_slot(1, ST_A, 1'b1, 7'd20);
        put_slot(3, LD_C, 1'b0, 7'd21);
        run_group(1'b0);
        new_group(1'b0);
        put_slot(0, LD_C, 1'b0, 7'd22);
        run_group(1'b0);
        train_pair(ST_D, LD_A);
        new_group(1'b0);
        put_slot(2, ST_D, 1'b1, 7'd30);
        run_group(1'b0);
        new_group(1'b0);
        put_slot(0, LD_A, 1'b0, 7'd31);
        run_group(1'b0);

        // second set and its merge into the smaller id
        train_pair(ST_B, LD_B);
        new_group(1'b1);
        put_slot(3, ST_B, 1'b1, 7'd40);
        run_group(1'b0);
        new_group(1'b0);
        put_slot(1, LD_B, 1'b0, 7'd41);
        run_group(1'b0);
        train_pair(ST_A, LD_B);
        new_group(1'b0);
        put_slot(0, ST_A, 1'b1, 7'd50);
        run_group(1'b0);
        new_group(1'b0);
        put_slot(0, LD_A, 1'b0, 7'd51);
        put_slot(1, LD_B, 1'b0, 7'd52);
        put_slot(2, LD_C, 1'b0, 7'd53);
        run_group(1'b0);

        // stalled store must not be recorded
        issue_store(0, ST_A, 7'd50);
        new_group(1'b0);
        put_slot(0, ST_A, 1'b1, 7'd60);
        put_slot(2, LD_A, 1'b0, 7'd61);
        run_group(1'b1);
        repeat (4) @(posedge clk);
        stall_chk <= 1'b0;
        @(posedge clk);
        stall    <= 1'b0;
        dispatch <= '0;
        new_group(1'b0);
        put_slot(1, LD_A, 1'b0, 7'd62);
        run_group(1'b0);
        idle_cycles(2);

        // periodic clear ages out all training
        while (cyc < CLEAR_PERIOD + 16) @(posedge clk);
        for (int p = 0; p < SSIT_ENTRIES; p++) begin
            m_vld[p] = 1'b0;
        end
        for (int e = 0; e < LFST_ENTRIES; e++) begin
            l_vld[e] = 1'b0;
        end
        new_group(1'b1);
        put_slot(0, ST_A, 1'b1, 7'd70);
        put_slot(2, LD_A, 1'b0, 7'd71);
        run_group(1'b0);
        new_group(1'b0);
        put_slot(0, LD_B, 1'b0, 7'd72);
        run_group(1'b0);
        idle_cycles(2);

        $display("Finished with no errors");
        $finish;
    end

    initial begin
        #((TEST_CYCLES + CLEAR_PERIOD + MARGIN_CYCLES) * CLK_PERIOD);
        $display("run timed out before all tests completed");
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== flist.f ====
source/memdep_pkg.sv
source/ssit.sv
source/lfst.sv
source/dep_resolve.sv
source/storeset.sv
verif/tb_clk_gen.sv
verif/tb_storeset.sv

// ==== Bender.yml ====
package:
  name: storeset

sources:
  - files:
      - source/memdep_pkg.sv
      - source/ssit.sv
      - source/lfst.sv
      - source/dep_resolve.sv
      - source/storeset.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_storeset.sv
